//--- Makefile
VERILATOR ?= verilator
TOP       ?= dmem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
dmem_pkg.sv
lsq.sv
dcache.sv
dcache_ctrl.sv
dmem.sv
dmem_tb.sv

//--- dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic        clock,
    input  logic        reset,
    input  logic        rd_en,
    input  logic [15:0] rd_addr,
    input  logic [1:0]  rd_size,
    input  logic        wr_en,
    input  logic [15:0] wr_addr,
    input  logic [1:0]  wr_size,
    input  logic [31:0] wr_data,
    input  logic        fill_en,
    input  logic [15:0] fill_addr,
    input  logic [63:0] fill_data,
    input  logic        st_ack,
    output logic        rd_hit,
    output logic [31:0] rd_data,
    output logic        miss_req,
    output logic [15:0] miss_addr,
    output logic        st_req,
    output logic [15:0] st_addr,
    output logic [1:0]  st_size,
    output logic [31:0] st_data
);

    logic [dmem_pkg::cache_lines-1:0] line_valid;
    logic [7:0]                       line_tag  [dmem_pkg::cache_lines];
    logic [63:0]                      line_data [dmem_pkg::cache_lines];

    dmem_pkg::dmem_addr_t rd_view;
    dmem_pkg::dmem_addr_t wr_view;
    dmem_pkg::dmem_addr_t fill_view;
    logic                 lookup_hit;
    logic                 wr_hit;
    logic [63:0]          size_mask;
    logic [63:0]          wr_mask;
    logic [63:0]          wr_shift;
    logic [63:0]          merged;

    assign rd_view   = rd_addr;
    assign wr_view   = wr_addr;
    assign fill_view = fill_addr;

    assign lookup_hit = line_valid[rd_view.fields.index]
        && line_tag[rd_view.fields.index] == rd_view.fields.tag;
    assign rd_hit  = rd_en && lookup_hit;
    assign rd_data = dmem_pkg::load_align(line_data[rd_view.fields.index],
                                          rd_view.fields.offset, rd_size);

    // held while the load sits at the queue head
    assign miss_req  = rd_en && !lookup_hit;
    assign miss_addr = {rd_view.fields.tag, rd_view.fields.index, 3'b000};

    // write-through without allocate
    assign st_req  = wr_en;
    assign st_addr = wr_addr;
    assign st_size = wr_size;
    assign st_data = wr_data;
    assign wr_hit  = wr_en && line_valid[wr_view.fields.index]
        && line_tag[wr_view.fields.index] == wr_view.fields.tag;

    always_comb begin
        case (wr_size)
            dmem_pkg::size_byte: size_mask = 64'h0000_0000_0000_00ff;
            dmem_pkg::size_half: size_mask = 64'h0000_0000_0000_ffff;
            dmem_pkg::size_word: size_mask = 64'h0000_0000_ffff_ffff;
            default:             size_mask = '1;
        endcase
        wr_mask  = size_mask << {wr_view.fields.offset, 3'b000};
        wr_shift = {32'h0, wr_data} << {wr_view.fields.offset, 3'b000};
        merged   = (line_data[wr_view.fields.index] & ~wr_mask) | (wr_shift & wr_mask);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_view.fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[fill_view.fields.index]  <= fill_view.fields.tag;
            line_data[fill_view.fields.index] <= fill_data;
        end else if (wr_hit && st_ack) begin
            line_data[wr_view.fields.index] <= merged; // update on bus accept
        end
    end

endmodule

`default_nettype wire

//--- dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic        clock,
    input  logic        reset,
    input  logic        miss_req,
    input  logic [15:0] miss_addr,
    input  logic        st_req,
    input  logic [15:0] st_addr,
    input  logic [1:0]  st_size,
    input  logic [31:0] st_data,
    input  logic [3:0]  mem2proc_response,
    input  logic [63:0] mem2proc_data,
    input  logic [3:0]  mem2proc_tag,
    output logic [1:0]  dmem_command,
    output logic [15:0] dmem_addr,
    output logic [1:0]  dmem_size,
    output logic [63:0] dmem_data,
    output logic        fill_en,
    output logic [15:0] fill_addr,
    output logic [63:0] fill_data,
    output logic        mem_done,
    output logic [63:0] mem_data,
    output logic        st_ack
);

    localparam logic [1:0] st_idle = 2'h0;
    localparam logic [1:0] st_req_out = 2'h1; // command on the bus
    localparam logic [1:0] st_wait = 2'h2;    // fetch accepted, tag pending

    logic [1:0]           state;
    logic [1:0]           cmd_q;
    dmem_pkg::dmem_addr_t addr_q;
    dmem_pkg::dmem_addr_t miss_view;
    logic [1:0]           size_q;
    logic [63:0]          data_q;
    logic [3:0]           tag_q;
    logic                 accepted;
    logic                 tag_hit;

    assign miss_view = miss_addr;

    assign dmem_command = (state == st_req_out) ? cmd_q : dmem_pkg::bus_none;
    assign dmem_addr    = addr_q.word;
    assign dmem_size    = size_q;
    assign dmem_data    = data_q;

    assign accepted = state == st_req_out && mem2proc_response != 4'h0;
    assign st_ack   = accepted && cmd_q == dmem_pkg::bus_store;
    assign tag_hit  = state == st_wait && mem2proc_tag != 4'h0 && mem2proc_tag == tag_q;

    // fill goes ahead even if the load was flushed
    assign fill_en   = tag_hit;
    assign fill_addr = addr_q.word;
    assign fill_data = mem2proc_data;

    // only the load still missing on this block takes the data
    assign mem_done = tag_hit && miss_req
        && miss_view.fields.tag == addr_q.fields.tag
        && miss_view.fields.index == addr_q.fields.index;
    assign mem_data = mem2proc_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (miss_req || st_req) begin
                        state <= st_req_out;
                    end
                end
                st_req_out: begin
                    if (accepted) begin
                        state <= (cmd_q == dmem_pkg::bus_load) ? st_wait : st_idle;
                    end
                end
                st_wait: begin
                    if (tag_hit) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            if (miss_req) begin
                cmd_q  <= dmem_pkg::bus_load;
                addr_q <= miss_addr;
                size_q <= dmem_pkg::size_double;
            end else if (st_req) begin
                cmd_q  <= dmem_pkg::bus_store;
                addr_q <= st_addr;
                size_q <= st_size;
                data_q <= {32'h0, st_data};
            end
        end
        if (accepted) begin
            tag_q <= mem2proc_response;
        end
    end

endmodule

`default_nettype wire

//--- dmem.sv
`timescale 1ns/1ps
`default_nettype none

module dmem #(
    parameter int lsq_size = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               except,
    input  logic                               ld_en,
    input  logic [1:0]                         ld_size,
    input  logic [dmem_pkg::rob_w-1:0]         ld_rob_idx,
    input  logic [dmem_pkg::prf_w-1:0]         ld_prf_idx,
    input  logic                               st_en,
    input  logic [1:0]                         st_size,
    input  logic [31:0]                        st_data,
    input  logic [dmem_pkg::rob_w-1:0]         st_rob_idx,
    input  logic                               commit,
    input  logic                               alu_is_valid,
    input  logic [dmem_pkg::rob_w-1:0]         alu_rob_idx,
    input  logic [31:0]                        alu_data,
    input  logic [3:0]                         mem2proc_response, // 0 = refused
    input  logic [63:0]                        mem2proc_data,
    input  logic [3:0]                         mem2proc_tag,
    output logic [$clog2(lsq_size):0]          lsq_num_free,
    output logic                               cdb_valid_out,
    output logic [31:0]                        cdb_data_out,
    output logic [dmem_pkg::prf_w-1:0]         cdb_prf_idx_out,
    output logic [dmem_pkg::rob_w-1:0]         cdb_rob_idx_out,
    output logic [1:0]                         dmem_command,
    output logic [15:0]                        dmem_addr,
    output logic [1:0]                         dmem_size,
    output logic [63:0]                        dmem_data
);

    // queue <-> cache
    logic        rd_en;
    logic [15:0] rd_addr;
    logic [1:0]  rd_size;
    logic        rd_hit;
    logic [31:0] rd_data;
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [1:0]  wr_size;
    logic [31:0] wr_data;

    // cache <-> controller
    logic        miss_req;
    logic [15:0] miss_addr;
    logic        st_req;
    logic [15:0] st_addr;
    logic [1:0]  st_req_size;
    logic [31:0] st_req_data;
    logic        fill_en;
    logic [15:0] fill_addr;
    logic [63:0] fill_data;

    // controller feedback to the queue
    logic        mem_done;
    logic [63:0] mem_data;
    logic        st_ack;

    lsq #(
        .lsq_size(lsq_size)
    ) lsq_inst (
        .clock, .reset, .except,
        .ld_en, .ld_size, .ld_rob_idx, .ld_prf_idx,
        .st_en, .st_size, .st_data, .st_rob_idx,
        .commit,
        .alu_is_valid, .alu_rob_idx, .alu_data,
        .rd_hit, .rd_data,
        .mem_done, .mem_data, .st_ack,
        .lsq_num_free,
        .rd_en, .rd_addr, .rd_size,
        .wr_en, .wr_addr, .wr_size, .wr_data,
        .cdb_valid_out, .cdb_data_out, .cdb_prf_idx_out, .cdb_rob_idx_out
    );

    dcache dcache_inst (
        .clock, .reset,
        .rd_en, .rd_addr, .rd_size,
        .wr_en, .wr_addr, .wr_size, .wr_data,
        .fill_en, .fill_addr, .fill_data,
        .st_ack,
        .rd_hit, .rd_data,
        .miss_req, .miss_addr,
        .st_req, .st_addr,
        .st_size(st_req_size),
        .st_data(st_req_data)
    );

    dcache_ctrl dcache_ctrl_inst (
        .clock, .reset,
        .miss_req, .miss_addr,
        .st_req, .st_addr,
        .st_size(st_req_size),
        .st_data(st_req_data),
        .mem2proc_response, .mem2proc_data, .mem2proc_tag,
        .dmem_command, .dmem_addr, .dmem_size, .dmem_data,
        .fill_en, .fill_addr, .fill_data,
        .mem_done, .mem_data, .st_ack
    );

endmodule

`default_nettype wire

//--- dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    localparam int rob_w       = 5;
    localparam int prf_w       = 6;
    localparam int cache_lines = 32; // 8-byte lines

    // memory bus commands
    localparam logic [1:0] bus_none  = 2'h0;
    localparam logic [1:0] bus_load  = 2'h1; // block fetch
    localparam logic [1:0] bus_store = 2'h2;

    localparam logic [1:0] size_byte   = 2'h0;
    localparam logic [1:0] size_half   = 2'h1;
    localparam logic [1:0] size_word   = 2'h2;
    localparam logic [1:0] size_double = 2'h3;

    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] tag;
            logic [4:0] index;
            logic [2:0] offset;
        } fields;
    } dmem_addr_t;

    // zero-extended load result picked out of a line
    function automatic logic [31:0] load_align(
        input logic [63:0] blk,
        input logic [2:0]  offset,
        input logic [1:0]  size
    );
        logic [63:0] sh;
        sh = blk >> {offset, 3'b000};
        case (size)
            size_byte: return {24'h0, sh[7:0]};
            size_half: return {16'h0, sh[15:0]};
            default:   return sh[31:0]; // double truncates to the low word
        endcase
    endfunction

endpackage

`default_nettype wire

//--- dmem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

    localparam int lsq_size  = 8;
    localparam int max_vecs  = 128;
    localparam int drain_max = 400; // cycles per drained segment

    logic                       clock;
    logic                       reset;
    logic                       except;
    logic                       ld_en;
    logic [1:0]                 ld_size;
    logic [dmem_pkg::rob_w-1:0] ld_rob_idx;
    logic [dmem_pkg::prf_w-1:0] ld_prf_idx;
    logic                       st_en;
    logic [1:0]                 st_size;
    logic [31:0]                st_data;
    logic [dmem_pkg::rob_w-1:0] st_rob_idx;
    logic                       commit;
    logic                       alu_is_valid;
    logic [dmem_pkg::rob_w-1:0] alu_rob_idx;
    logic [31:0]                alu_data;
    logic [3:0]                 mem2proc_response;
    logic [63:0]                mem2proc_data;
    logic [3:0]                 mem2proc_tag;
    logic [$clog2(lsq_size):0]  lsq_num_free;
    logic                       cdb_valid_out;
    logic [31:0]                cdb_data_out;
    logic [dmem_pkg::prf_w-1:0] cdb_prf_idx_out;
    logic [dmem_pkg::rob_w-1:0] cdb_rob_idx_out;
    logic [1:0]                 dmem_command;
    logic [15:0]                dmem_addr;
    logic [1:0]                 dmem_size;
    logic [63:0]                dmem_data;

    logic [31:0] vec [max_vecs*5]; // five columns per line
    logic [7:0]  mem_bytes [65536];
    logic [42:0] exp_loads [$];    // {rob, prf, data}
    logic [49:0] exp_stores [$];   // {size, addr, data}

    int          errors;
    int          checks;
    int          fetches;
    bit          timed_out;
    bit          fetch_pending;
    int          fetch_delay;
    logic [3:0]  fetch_tag;
    logic [63:0] fetch_block;
    logic [3:0]  next_tag;

    dmem #(
        .lsq_size(lsq_size)
    ) dmem_inst (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    function automatic logic [63:0] read_block(input logic [15:0] base);
        logic [63:0] blk;
        for (int i = 0; i < 8; i++) begin
            blk[i*8 +: 8] = mem_bytes[base + 16'(i)];
        end
        return blk;
    endfunction

    task automatic write_bytes(input logic [15:0] addr, input logic [1:0] size,
                               input logic [63:0] data);
        for (int i = 0; i < (1 << size); i++) begin
            mem_bytes[addr + 16'(i)] = data[i*8 +: 8];
        end
    endtask

    task automatic match_store();
        logic [49:0] expected;
        if (exp_stores.size() == 0) begin
            errors++;
            $display("store to %h at %0t was not expected", dmem_addr, $time);
        end else begin
            expected = exp_stores.pop_front();
            check_value("dmem_addr", 64'(dmem_addr), 64'(expected[47:32]));
            check_value("dmem_size", 64'(dmem_size), 64'(expected[49:48]));
            check_value("dmem_data", dmem_data, {32'h0, expected[31:0]});
        end
    endtask

    // memory model answers 1 ns after each rising edge
    initial begin
        void'($urandom(32'hc748));
        mem2proc_response = 4'h0;
        mem2proc_data     = 64'h0;
        mem2proc_tag      = 4'h0;
        fetch_pending     = 1'b0;
        next_tag          = 4'h1;
        for (int a = 0; a < 65536; a++) begin
            mem_bytes[a] = 8'(a) ^ 8'(a >> 8);
        end
        forever begin
            @(posedge clock);
            #1;
            mem2proc_response = 4'h0;
            mem2proc_tag      = 4'h0;
            if (fetch_pending) begin
                if (fetch_delay == 0) begin
                    mem2proc_tag  = fetch_tag;
                    mem2proc_data = fetch_block;
                    fetch_pending = 1'b0;
                end else begin
                    fetch_delay--;
                end
            end
            // one in three requests refused
            if (dmem_command != dmem_pkg::bus_none && $urandom_range(2, 0) != 0) begin
                mem2proc_response = next_tag;
                next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
                if (dmem_command == dmem_pkg::bus_load) begin
                    fetches++;
                    check_value("dmem_addr[2:0]", 64'(dmem_addr[2:0]), 64'h0);
                    fetch_block   = read_block({dmem_addr[15:3], 3'b000});
                    fetch_tag     = mem2proc_response;
                    fetch_delay   = $urandom_range(5, 1); // data 2 to 6 cycles later
                    fetch_pending = 1'b1;
                end else begin
                    match_store();
                    write_bytes(dmem_addr, dmem_size, dmem_data);
                end
            end
        end
    end

    always @(negedge clock) begin : cdb_monitor
        logic [42:0] expected;
        if (!reset && cdb_valid_out) begin
            if (exp_loads.size() == 0) begin
                errors++;
                $display("CDB result for rob %0d at %0t with no load outstanding",
                         cdb_rob_idx_out, $time);
            end else begin
                expected = exp_loads.pop_front();
                check_value("cdb_rob_idx_out", 64'(cdb_rob_idx_out), 64'(expected[42:38]));
                check_value("cdb_prf_idx_out", 64'(cdb_prf_idx_out), 64'(expected[37:32]));
                check_value("cdb_data_out", 64'(cdb_data_out), 64'(expected[31:0]));
            end
        end
    end

    // wait until queue, bus and memory model are all quiet
    task automatic drain_queue(input logic [31:0] exp_fetches);
        int n;
        n = 0;
        forever begin
            @(negedge clock);
            if (lsq_num_free == lsq_size && exp_loads.size() == 0 && exp_stores.size() == 0
                && !fetch_pending && mem2proc_tag == 4'h0
                && dmem_command == dmem_pkg::bus_none) begin
                break;
            end
            n++;
            if (n > drain_max) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout at %0t: queue did not drain within %0d cycles",
                         $time, drain_max);
                break;
            end
        end
        if (!timed_out) begin
            check_value("block fetch count", 64'(fetches), 64'(exp_fetches));
        end
    endtask

    initial begin
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          idx;
        errors       = 0;
        checks       = 0;
        fetches      = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        except       = 1'b0;
        ld_en        = 1'b0;
        ld_size      = 2'h0;
        ld_rob_idx   = '0;
        ld_prf_idx   = '0;
        st_en        = 1'b0;
        st_size      = 2'h0;
        st_data      = 32'h0;
        st_rob_idx   = '0;
        commit       = 1'b0;
        alu_is_valid = 1'b0;
        alu_rob_idx  = '0;
        alu_data     = 32'h0;
        $readmemh("dmem_vectors.txt", vec);
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        idx = 0;
        while (!timed_out && idx < max_vecs && vec[idx*5] != 32'h0) begin
            op = vec[idx*5][3:0];
            a  = vec[idx*5+1];
            b  = vec[idx*5+2];
            c  = vec[idx*5+3];
            d  = vec[idx*5+4];
            @(posedge clock);
            #1;
            ld_en        = 1'b0;
            st_en        = 1'b0;
            commit       = 1'b0;
            except       = 1'b0;
            alu_is_valid = 1'b0;
            case (op)
                4'h1: begin
                    ld_en      = 1'b1;
                    ld_size    = a[1:0];
                    ld_rob_idx = b[dmem_pkg::rob_w-1:0];
                    ld_prf_idx = c[dmem_pkg::prf_w-1:0];
                    exp_loads.push_back({b[dmem_pkg::rob_w-1:0], c[dmem_pkg::prf_w-1:0], d});
                end
                4'h2: begin
                    st_en      = 1'b1;
                    st_size    = a[1:0];
                    st_rob_idx = b[dmem_pkg::rob_w-1:0];
                    st_data    = c;
                    exp_stores.push_back({a[1:0], d[15:0], c});
                end
                4'h3: begin
                    alu_is_valid = 1'b1;
                    alu_rob_idx  = a[dmem_pkg::rob_w-1:0];
                    alu_data     = b;
                end
                4'h4: commit = 1'b1;
                4'h5: begin
                    except = 1'b1;
                    exp_loads.delete(); // flushed loads never broadcast
                end
                4'h6: drain_queue(a);
                4'h7: check_value("lsq_num_free", 64'(lsq_num_free), 64'(a));
                default: begin
                    errors++;
                    $display("unknown operation %h on vector line %0d", op, idx);
                end
            endcase
            idx++;
        end

        if (exp_loads.size() != 0 || exp_stores.size() != 0) begin
            errors++;
            $display("%0d loads and %0d stores still outstanding at the end",
                     exp_loads.size(), exp_stores.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dmem_vectors.txt
// columns (hex): op a b c d; sizes 0 byte, 1 half, 2 word, 3 double
// op 1 load size rob prf result, 2 store size rob data bus_addr, 3 alu rob addr,
// op 4 commit, 5 except, 6 drain total_fetches, 7 free lsq_num_free, 0 end
7 8 0 0 0
1 2 01 0a 21202322
7 7 0 0 0
1 0 02 0b 00000027
7 6 0 0 0
3 01 1230 0 0
3 02 1235 0 0
6 1 0 0 0
// sizes and offsets, addresses given out of order
1 1 03 0c 00004b4a
1 2 04 0d 4f4e4d4c
1 0 05 0e 0000004f
1 0 06 0f 000000fd
1 1 07 10 00004a49
3 07 4009 0 0
3 06 8a77 0 0
3 05 400f 0 0
3 04 400c 0 0
3 03 400a 0 0
6 3 0 0 0
// write-through stores, merge into a cached line and refetch of an uncached one
2 2 08 deadbeef 1234
4 0 0 0 0
3 08 1234 0 0
1 2 09 11 deadbeef
3 09 1234 0 0
2 0 0a 777777a5 5003
4 0 0 0 0
3 0a 5003 0 0
1 1 0b 12 0000a552
3 0b 5002 0 0
2 1 0c cafe1357 1230
3 0c 1230 0 0
4 0 0 0 0
1 2 0d 13 21201357
3 0d 1230 0 0
6 4 0 0 0
// exception flushes both loads, the fetch still fills line 8
1 2 10 14 d9d8dbda
1 0 11 15 00000020
3 10 9a40 0 0
3 11 1232 0 0
5 0 0 0 0
7 8 0 0 0
6 5 0 0 0
1 0 12 16 000000de
3 12 9a44 0 0
6 5 0 0 0
0 0 0 0 0

//--- lsq.sv
`timescale 1ns/1ps
`default_nettype none

module lsq #(
    parameter int lsq_size = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               except,
    input  logic                               ld_en,
    input  logic [1:0]                         ld_size,
    input  logic [dmem_pkg::rob_w-1:0]         ld_rob_idx,
    input  logic [dmem_pkg::prf_w-1:0]         ld_prf_idx,
    input  logic                               st_en,
    input  logic [1:0]                         st_size,
    input  logic [31:0]                        st_data,
    input  logic [dmem_pkg::rob_w-1:0]         st_rob_idx,
    input  logic                               commit,
    input  logic                               alu_is_valid,
    input  logic [dmem_pkg::rob_w-1:0]         alu_rob_idx,
    input  logic [31:0]                        alu_data,
    input  logic                               rd_hit,
    input  logic [31:0]                        rd_data,
    input  logic                               mem_done,
    input  logic [63:0]                        mem_data,
    input  logic                               st_ack,
    output logic [$clog2(lsq_size):0]          lsq_num_free,
    output logic                               rd_en,
    output logic [15:0]                        rd_addr,
    output logic [1:0]                         rd_size,
    output logic                               wr_en,
    output logic [15:0]                        wr_addr,
    output logic [1:0]                         wr_size,
    output logic [31:0]                        wr_data,
    output logic                               cdb_valid_out,
    output logic [31:0]                        cdb_data_out,
    output logic [dmem_pkg::prf_w-1:0]         cdb_prf_idx_out,
    output logic [dmem_pkg::rob_w-1:0]         cdb_rob_idx_out
);

    localparam int ptr_w = $clog2(lsq_size);
    localparam int cnt_w = ptr_w + 1;

    logic                         is_load [lsq_size];
    logic [1:0]                   size    [lsq_size];
    logic [dmem_pkg::rob_w-1:0]   rob_idx [lsq_size];
    logic [dmem_pkg::prf_w-1:0]   prf_idx [lsq_size];
    dmem_pkg::dmem_addr_t         addr    [lsq_size];
    logic [31:0]                  data    [lsq_size];
    logic [lsq_size-1:0]          addr_valid;
    logic [lsq_size-1:0]          waiting; // miss sent, fill pending

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] credits;
    logic             empty;
    logic             head_ready;
    logic             push;
    logic             pop_hit;
    logic             pop_mem;
    logic             pop_st;
    logic             pop;
    logic [31:0]      load_result;

    assign empty      = lsq_num_free == cnt_w'(lsq_size);
    assign head_ready = !empty && addr_valid[head];
    assign push       = ld_en || st_en;

    assign rd_en   = head_ready && is_load[head];
    assign rd_addr = addr[head].word;
    assign rd_size = size[head];

    // store needs a commit credit before it may go out
    assign wr_en   = head_ready && !is_load[head] && credits != '0;
    assign wr_addr = addr[head].word;
    assign wr_size = size[head];
    assign wr_data = data[head];

    assign pop_hit = rd_en && rd_hit;
    assign pop_mem = rd_en && waiting[head] && mem_done;
    assign pop_st  = wr_en && st_ack;
    assign pop     = pop_hit || pop_mem || pop_st;

    assign load_result = pop_hit ? rd_data :
        dmem_pkg::load_align(mem_data, addr[head].fields.offset, size[head]);

    always_ff @(posedge clock) begin
        if (reset || except) begin
            head          <= '0;
            tail          <= '0;
            lsq_num_free  <= cnt_w'(lsq_size);
            credits       <= '0;
            cdb_valid_out <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            lsq_num_free  <= lsq_num_free - cnt_w'(push) + cnt_w'(pop);
            credits       <= credits + cnt_w'(commit) - cnt_w'(pop_st);
            cdb_valid_out <= pop_hit || pop_mem;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            addr_valid <= '0;
            waiting    <= '0;
        end else begin
            for (int i = 0; i < lsq_size; i++) begin
                if (alu_is_valid && rob_idx[i] == alu_rob_idx) begin
                    addr_valid[i] <= 1'b1;
                end
            end
            if (rd_en && !rd_hit) begin
                waiting[head] <= 1'b1;
            end
            if (push) begin // new entry overrides stale matches
                addr_valid[tail] <= 1'b0;
                waiting[tail]    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < lsq_size; i++) begin
            if (alu_is_valid && rob_idx[i] == alu_rob_idx) begin
                addr[i].word <= alu_data[15:0];
            end
        end
        if (push) begin
            is_load[tail] <= ld_en;
            size[tail]    <= ld_en ? ld_size : st_size;
            rob_idx[tail] <= ld_en ? ld_rob_idx : st_rob_idx;
            prf_idx[tail] <= ld_prf_idx;
            data[tail]    <= st_data;
        end
    end

    always_ff @(posedge clock) begin
        if (pop_hit || pop_mem) begin
            cdb_data_out    <= load_result;
            cdb_prf_idx_out <= prf_idx[head];
            cdb_rob_idx_out <= rob_idx[head];
        end
    end

endmodule

`default_nettype wire
